// ==== vseq_cfg.svh ====
// Sizes are fixed at compile time; NR_LANES may be 1, 2 or 4 and NR_VINSN must be a power of two
`ifndef VSEQ_CFG_SVH
`define VSEQ_CFG_SVH

// Parallel lanes
`define VSEQ_NR_LANES 2

// Instruction ids in flight
`define VSEQ_NR_VINSN 4

// Architectural vector registers, v0 holds the mask
`define VSEQ_NR_VREGS 32

// PEs are the lanes, then load, store and mask units
`define VSEQ_NR_PES (`VSEQ_NR_LANES + 3)
`define VSEQ_PE_LOAD (`VSEQ_NR_LANES)
`define VSEQ_PE_STORE (`VSEQ_NR_LANES + 1)
`define VSEQ_PE_MASK (`VSEQ_NR_LANES + 2)

`endif

// ==== source/vseq_pkg.sv ====
// Shared types only; opcodes are symbolic and carry no real ISA encoding
`include "vseq_cfg.svh"

package vseq_pkg;

  // Widths with a meaning
  typedef logic [$clog2(`VSEQ_NR_VINSN)-1:0] vid_t;
  typedef logic [$clog2(`VSEQ_NR_VREGS)-1:0] vreg_t;
  typedef logic [7:0]                        vlen_t;
  typedef logic [31:0]                       xlen_t;

  // One bit per instruction id, one bit per PE
  typedef logic [`VSEQ_NR_VINSN-1:0] vinsn_mask_t;
  typedef logic [`VSEQ_NR_PES-1:0]   pe_mask_t;

  // Supported operations
  typedef enum logic [2:0] {
    VADD,
    VMUL,
    VMAND,
    VLE,
    VSE,
    VCPOP
  } vop_e;

  // Functional unit that owns an operation
  typedef enum logic [1:0] {
    LANES,
    LOAD,
    STORE,
    MASK
  } vfu_e;

  // Sequencer FSM
  typedef enum logic {
    IDLE,
    WAIT
  } vseq_state_e;

  // Request from the dispatcher
  typedef struct packed {
    vop_e  op;
    vreg_t vd;
    logic  use_vd;
    vreg_t vs1;
    logic  use_vs1;
    vreg_t vs2;
    logic  use_vs2;
    // High means unmasked
    logic  vm;
    vlen_t vl;
    xlen_t scalar_op;
  } disp_req_t;

  // Decoder verdict
  typedef struct packed {
    vfu_e vfu;
    logic needs_addr_ack;
    logic needs_scalar_resp;
  } decoded_t;

  // Commit answer back to the dispatcher
  typedef struct packed {
    xlen_t result;
    logic  error;
  } disp_resp_t;

  // Request broadcast to every PE
  typedef struct packed {
    vid_t        id;
    vop_e        op;
    vfu_e        vfu;
    logic        vm;
    vlen_t       vl;
    xlen_t       scalar_op;
    vinsn_mask_t hazard_vs1;
    vinsn_mask_t hazard_vs2;
    vinsn_mask_t hazard_vm;
    vinsn_mask_t hazard_vd;
  } pe_req_t;

endpackage

// ==== source/vseq_decode.sv ====
// Purely combinational; an unknown opcode falls back to the lanes with no commit wait
`timescale 1ns/10ps

module vseq_decode import vseq_pkg::*; (
  input  disp_req_t req_i,
  output decoded_t  dec_o
);

  // All opcode knowledge lives here
  always_comb begin : p_decode
    dec_o.vfu               = LANES;
    dec_o.needs_addr_ack    = 1'b0;
    dec_o.needs_scalar_resp = 1'b0;

    unique case (req_i.op)
      // Arithmetic runs on every lane
      VADD, VMUL: begin
        dec_o.vfu = LANES;
      end
      // Mask logical op writes a mask register
      VMAND: begin
        dec_o.vfu = MASK;
      end
      // Population count has no vd and answers with a scalar
      VCPOP: begin
        dec_o.vfu               = MASK;
        dec_o.needs_scalar_resp = 1'b1;
      end
      // Memory ops commit once the address is checked
      VLE: begin
        dec_o.vfu            = LOAD;
        dec_o.needs_addr_ack = 1'b1;
      end
      VSE: begin
        dec_o.vfu            = STORE;
        dec_o.needs_addr_ack = 1'b1;
      end
      default: begin
        dec_o.vfu = LANES;
      end
    endcase
    // Masked ops also occupy the mask unit, which the sequencer adds from vm
  end

endmodule

// ==== source/vseq_sequencer.sv ====
// One commit may be outstanding at a time; the dispatcher must hold req_i until it is taken
`timescale 1ns/10ps
`include "vseq_cfg.svh"

module vseq_sequencer import vseq_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Dispatcher side
  input  disp_req_t                      req_i,
  input  decoded_t                       dec_i,
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  output disp_resp_t                     resp_o,
  output logic                           resp_valid_o,
  output logic                           idle_o,
  // PE side
  output pe_req_t                        pe_req_o,
  output logic                           pe_req_valid_o,
  output vinsn_mask_t                    running_o,
  input  pe_mask_t                       pe_ready_i,
  input  vinsn_mask_t [`VSEQ_NR_PES-1:0] pe_done_i,
  // Address check and scalar answer
  input  logic                           addr_ack_i,
  input  logic                           addr_error_i,
  input  xlen_t                          scalar_i,
  input  logic                           scalar_valid_i
);

  // v0 is the mask source
  localparam vreg_t VMASK = vreg_t'(0);

  // Last access to a register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  // Ids running per PE and overall
  vinsn_mask_t [`VSEQ_NR_PES-1:0] pe_run_d, pe_run_q, pe_left;
  vinsn_mask_t                    running_d, running_q, running_left;

  vid_t        next_id;
  logic        ids_full;
  logic        struct_hazard;
  logic        can_issue;
  logic        issue;
  logic        commit;
  vseq_state_e state_d, state_q;
  pe_req_t     pe_req_d;

  vreg_access_t [`VSEQ_NR_VREGS-1:0] read_list_d, read_list_q;
  vreg_access_t [`VSEQ_NR_VREGS-1:0] write_list_d, write_list_q;

  assign running_o    = running_q;
  assign idle_o       = ~|running_q;
  assign resp_valid_o = commit;

  // Lowest free id, scanning down so the last hit wins
  always_comb begin : p_next_id
    next_id  = '0;
    ids_full = &running_q;
    for (int i = `VSEQ_NR_VINSN - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        next_id = vid_t'(i);
      end
    end
  end

  // Done pulses retire ids per PE
  always_comb begin : p_retire
    running_left = '0;
    for (int pe = 0; pe < `VSEQ_NR_PES; pe++) begin
      pe_left[pe]  = pe_run_q[pe] & ~pe_done_i[pe];
      running_left = running_left | pe_left[pe];
    end
  end

  // Store and mask unit share a queue in the full design
  assign struct_hazard = (dec_i.vfu == STORE && |pe_run_q[`VSEQ_PE_MASK]) ||
                         (dec_i.vfu == MASK && |pe_run_q[`VSEQ_PE_STORE]);
  assign can_issue     = &pe_ready_i && !ids_full && !struct_hazard;

  always_comb begin : p_sequencer
    state_d      = state_q;
    pe_run_d     = pe_left;
    read_list_d  = read_list_q;
    write_list_d = write_list_q;
    issue        = 1'b0;
    commit       = 1'b0;
    resp_o       = '0;
    req_ready_o  = 1'b0;

    // Held request keeps only hazards on ids still running
    pe_req_d            = pe_req_o;
    pe_req_d.hazard_vs1 = pe_req_o.hazard_vs1 & running_left;
    pe_req_d.hazard_vs2 = pe_req_o.hazard_vs2 & running_left;
    pe_req_d.hazard_vm  = pe_req_o.hazard_vm & running_left;
    pe_req_d.hazard_vd  = pe_req_o.hazard_vd & running_left;

    // Access entries lapse when their id stops
    for (int v = 0; v < `VSEQ_NR_VREGS; v++) begin
      read_list_d[v].valid  = read_list_q[v].valid & running_q[read_list_q[v].vid];
      write_list_d[v].valid = write_list_q[v].valid & running_q[write_list_q[v].vid];
    end

    unique case (state_q)
      IDLE: begin
        // Ops with a commit answer are taken later, in WAIT
        req_ready_o = can_issue && !dec_i.needs_addr_ack && !dec_i.needs_scalar_resp;
        if (req_valid_i && can_issue) begin
          issue = 1'b1;
          if (dec_i.needs_addr_ack || dec_i.needs_scalar_resp) begin
            state_d = WAIT;
          end

          // Record where the id runs
          unique case (dec_i.vfu)
            LOAD:    pe_run_d[`VSEQ_PE_LOAD][next_id] = 1'b1;
            STORE:   pe_run_d[`VSEQ_PE_STORE][next_id] = 1'b1;
            MASK:    pe_run_d[`VSEQ_PE_MASK][next_id] = 1'b1;
            default: begin
              for (int l = 0; l < `VSEQ_NR_LANES; l++) begin
                pe_run_d[l][next_id] = 1'b1;
              end
            end
          endcase
          // Masked op needs the mask unit too
          if (!req_i.vm) begin
            pe_run_d[`VSEQ_PE_MASK][next_id] = 1'b1;
          end

          pe_req_d = '{
            id       : next_id,
            op       : req_i.op,
            vfu      : dec_i.vfu,
            vm       : req_i.vm,
            vl       : req_i.vl,
            scalar_op: req_i.scalar_op,
            default  : '0
          };

          // RAW against the last writer
          if (req_i.use_vs1) begin
            pe_req_d.hazard_vs1[write_list_d[req_i.vs1].vid] |= write_list_d[req_i.vs1].valid;
          end
          if (req_i.use_vs2) begin
            pe_req_d.hazard_vs2[write_list_d[req_i.vs2].vid] |= write_list_d[req_i.vs2].valid;
          end
          if (!req_i.vm) begin
            pe_req_d.hazard_vm[write_list_d[VMASK].vid] |= write_list_d[VMASK].valid;
          end

          // WAR and WAW on vd
          if (req_i.use_vd) begin
            pe_req_d.hazard_vs1[read_list_d[req_i.vd].vid] |= read_list_d[req_i.vd].valid;
            pe_req_d.hazard_vs2[read_list_d[req_i.vd].vid] |= read_list_d[req_i.vd].valid;
            pe_req_d.hazard_vm[read_list_d[req_i.vd].vid]  |= read_list_d[req_i.vd].valid;
            pe_req_d.hazard_vd[write_list_d[req_i.vd].vid] |= write_list_d[req_i.vd].valid;
          end

          // This id becomes the last accessor
          if (req_i.use_vd) begin
            write_list_d[req_i.vd] = '{vid: next_id, valid: 1'b1};
          end
          if (req_i.use_vs1) begin
            read_list_d[req_i.vs1] = '{vid: next_id, valid: 1'b1};
          end
          if (req_i.use_vs2) begin
            read_list_d[req_i.vs2] = '{vid: next_id, valid: 1'b1};
          end
          if (!req_i.vm) begin
            read_list_d[VMASK] = '{vid: next_id, valid: 1'b1};
          end
        end
      end

      WAIT: begin
        // Held request still selects which answer to wait for
        if (dec_i.needs_addr_ack && addr_ack_i) begin
          commit       = 1'b1;
          resp_o.error = addr_error_i;
        end
        if (dec_i.needs_scalar_resp && scalar_valid_i) begin
          commit        = 1'b1;
          resp_o.result = scalar_i;
        end
        // Answer and acceptance share the cycle
        if (commit) begin
          req_ready_o = 1'b1;
          state_d     = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  // Union of all PEs, new ids included
  always_comb begin : p_running
    running_d = '0;
    for (int pe = 0; pe < `VSEQ_NR_PES; pe++) begin
      running_d = running_d | pe_run_d[pe];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_sequencer_ff
    if (!rst_ni) begin
      state_q        <= IDLE;
      pe_run_q       <= '0;
      running_q      <= '0;
      read_list_q    <= '0;
      write_list_q   <= '0;
      pe_req_valid_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      pe_run_q       <= pe_run_d;
      running_q      <= running_d;
      read_list_q    <= read_list_d;
      write_list_q   <= write_list_d;
      pe_req_valid_o <= issue;
    end
  end

  // Issue register, one cycle behind acceptance
  always_ff @(posedge clk_i) begin : p_pe_req_ff
    pe_req_o <= pe_req_d;
  end

endmodule

// ==== source/vseq_units.sv ====
// Timing-only PE models with no element data; VCPOP answers vl as if all elements were active
`timescale 1ns/10ps
`include "vseq_cfg.svh"

module vseq_units import vseq_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  pe_req_t                        pe_req_i,
  input  logic                           pe_req_valid_i,
  input  vinsn_mask_t                    running_i,
  output pe_mask_t                       pe_ready_o,
  output vinsn_mask_t [`VSEQ_NR_PES-1:0] pe_done_o,
  output logic                           addr_ack_o,
  output logic                           addr_error_o,
  output xlen_t                          scalar_o,
  output logic                           scalar_valid_o
);

  for (genvar p = 0; p < `VSEQ_NR_PES; p++) begin : g_pe
    // Two-entry queue, head is the running one
    pe_req_t     q_mem [2];
    vinsn_mask_t haz_q [2];
    logic        wr_q, rd_q;
    logic [1:0]  fill_q;
    logic        busy_q;
    vlen_t       left_q;
    pe_req_t     head;
    vlen_t       elems;
    logic        unit_hit, enq, start, done;

    // Which broadcast requests belong here
    always_comb begin : p_hit
      if (p < `VSEQ_NR_LANES) begin
        unit_hit = pe_req_i.vfu == LANES;
      end else if (p == `VSEQ_PE_LOAD) begin
        unit_hit = pe_req_i.vfu == LOAD;
      end else if (p == `VSEQ_PE_STORE) begin
        unit_hit = pe_req_i.vfu == STORE;
      end else begin
        unit_hit = pe_req_i.vfu == MASK || !pe_req_i.vm;
      end
    end

    assign enq  = pe_req_valid_i && unit_hit;
    assign head = q_mem[rd_q];

    // Lanes split the vector, ceiling division
    assign elems = (p < `VSEQ_NR_LANES) ?
        vlen_t'((9'(head.vl) + 9'(`VSEQ_NR_LANES - 1)) / 9'(`VSEQ_NR_LANES)) : head.vl;

    // Start once no producer or reader id is still live
    assign start = !busy_q && fill_q != 2'd0 && (haz_q[rd_q] & running_i) == '0;
    assign done  = busy_q && left_q <= vlen_t'(1);

    // Counts the request in flight so nothing overflows
    assign pe_ready_o[p] = fill_q == 2'd0 || (fill_q == 2'd1 && !enq);
    // Empty queue head holds no id yet
    assign pe_done_o[p]  = done ? (vinsn_mask_t'(1) << head.id) : '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
      if (!rst_ni) begin
        wr_q   <= 1'b0;
        rd_q   <= 1'b0;
        fill_q <= 2'd0;
        busy_q <= 1'b0;
        left_q <= '0;
      end else begin
        if (enq) begin
          wr_q <= ~wr_q;
        end
        if (done) begin
          rd_q <= ~rd_q;
        end
        fill_q <= fill_q + 2'(enq) - 2'(done);
        if (start) begin
          busy_q <= 1'b1;
          left_q <= elems;
        end else if (done) begin
          busy_q <= 1'b0;
        end else if (busy_q) begin
          left_q <= left_q - vlen_t'(1);
        end
      end
    end

    // Hazard bits drop for good once the id retires, so a reused id is never waited on
    always_ff @(posedge clk_i) begin : p_queue
      for (int i = 0; i < 2; i++) begin
        haz_q[i] <= haz_q[i] & running_i;
      end
      if (enq) begin
        q_mem[wr_q] <= pe_req_i;
        haz_q[wr_q] <= (pe_req_i.hazard_vs1 | pe_req_i.hazard_vs2 |
                        pe_req_i.hazard_vm | pe_req_i.hazard_vd) & running_i;
      end
    end

    // Population count ends on the mask unit
    if (p == `VSEQ_PE_MASK) begin : g_scalar
      assign scalar_valid_o = done && head.op == VCPOP;
      assign scalar_o       = xlen_t'(head.vl);
    end
  end

  // Load and store check the base address on entry
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_addr_ack
    if (!rst_ni) begin
      addr_ack_o   <= 1'b0;
      addr_error_o <= 1'b0;
    end else begin
      addr_ack_o   <= pe_req_valid_i && (pe_req_i.vfu == LOAD || pe_req_i.vfu == STORE);
      // Misaligned when the low bits are set
      addr_error_o <= pe_req_valid_i && (pe_req_i.vfu == LOAD || pe_req_i.vfu == STORE) &&
                      pe_req_i.scalar_op[1:0] != 2'b00;
    end
  end

endmodule

// ==== source/vseq_top.sv ====
// Dispatcher must hold req_i until req_ready_o; PE traffic comes out for observation only
`timescale 1ns/10ps
`include "vseq_cfg.svh"

module vseq_top import vseq_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  disp_req_t                      req_i,
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  output disp_resp_t                     resp_o,
  output logic                           resp_valid_o,
  output logic                           idle_o,
  output pe_req_t                        pe_req_o,
  output logic                           pe_req_valid_o,
  output vinsn_mask_t [`VSEQ_NR_PES-1:0] pe_done_o
);

  decoded_t    dec;
  pe_mask_t    pe_ready;
  vinsn_mask_t running;
  logic        addr_ack;
  logic        addr_error;
  xlen_t       scalar;
  logic        scalar_valid;

  // Decode
  vseq_decode decode_i (
    .req_i(req_i),
    .dec_o(dec)
  );

  // Issue, hazards and commit
  vseq_sequencer sequencer_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .dec_i         (dec),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .resp_o        (resp_o),
    .resp_valid_o  (resp_valid_o),
    .idle_o        (idle_o),
    .pe_req_o      (pe_req_o),
    .pe_req_valid_o(pe_req_valid_o),
    .running_o     (running),
    .pe_ready_i    (pe_ready),
    .pe_done_i     (pe_done_o),
    .addr_ack_i    (addr_ack),
    .addr_error_i  (addr_error),
    .scalar_i      (scalar),
    .scalar_valid_i(scalar_valid)
  );

  // Execution units
  vseq_units units_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pe_req_i      (pe_req_o),
    .pe_req_valid_i(pe_req_valid_o),
    .running_i     (running),
    .pe_ready_o    (pe_ready),
    .pe_done_o     (pe_done_o),
    .addr_ack_o    (addr_ack),
    .addr_error_o  (addr_error),
    .scalar_o      (scalar),
    .scalar_valid_o(scalar_valid)
  );

endmodule

// ==== bench/vseq_properties.sv ====
// Bound to vseq_top; assumes issue one cycle after acceptance and the default PE order
`timescale 1ns/10ps
`include "vseq_cfg.svh"

module vseq_properties import vseq_pkg::*; (
  input logic                           clk_i,
  input logic                           rst_ni,
  input disp_req_t                      req_i,
  input logic                           req_valid_i,
  input logic                           req_ready_o,
  input disp_resp_t                     resp_o,
  input logic                           resp_valid_o,
  input logic                           idle_o,
  input pe_req_t                        pe_req_o,
  input logic                           pe_req_valid_o,
  input vinsn_mask_t [`VSEQ_NR_PES-1:0] pe_done_o
);

  int unsigned err_count;

  // Reference model of what runs where
  disp_req_t                      last_req;
  vinsn_mask_t [`VSEQ_NR_PES-1:0] pe_live;
  vinsn_mask_t [`VSEQ_NR_PES-1:0] pe_next;
  vinsn_mask_t                    live;
  vinsn_mask_t                    live_next;
  vinsn_mask_t                    done_all;
  logic                           out_of_reset;

  // Last writer and last reader per register
  vid_t        wr_id [`VSEQ_NR_VREGS];
  logic        wr_ok [`VSEQ_NR_VREGS];
  vid_t        rd_id [`VSEQ_NR_VREGS];
  logic        rd_ok [`VSEQ_NR_VREGS];
  vinsn_mask_t dep   [`VSEQ_NR_VINSN];

  // Expected hazards of the request on the issue strobe
  vinsn_mask_t raw_vs1;
  vinsn_mask_t raw_vs2;
  vinsn_mask_t raw_vm;
  vinsn_mask_t war;
  vinsn_mask_t waw;
  logic        order_bad;

  // Outstanding commit
  logic  pending;
  logic  exp_err;
  logic  exp_scalar;
  vlen_t exp_vl;

  function automatic logic pe_takes(input int pe, input disp_req_t r);
    if (pe < `VSEQ_NR_LANES) begin
      return r.op == VADD || r.op == VMUL;
    end else if (pe == `VSEQ_PE_LOAD) begin
      return r.op == VLE;
    end else if (pe == `VSEQ_PE_STORE) begin
      return r.op == VSE;
    end
    // Mask unit also serves every masked op
    return r.op == VMAND || r.op == VCPOP || !r.vm;
  endfunction

  always_comb begin : p_next
    live      = '0;
    live_next = '0;
    done_all  = '0;
    for (int pe = 0; pe < `VSEQ_NR_PES; pe++) begin
      pe_next[pe] = pe_live[pe] & ~pe_done_o[pe];
      if (pe_req_valid_o && pe_takes(pe, last_req)) begin
        pe_next[pe][pe_req_o.id] = 1'b1;
      end
      live      = live | pe_live[pe];
      live_next = live_next | pe_next[pe];
      done_all  = done_all | pe_done_o[pe];
    end
  end

  always_comb begin : p_expected
    raw_vs1 = '0;
    raw_vs2 = '0;
    raw_vm  = '0;
    war     = '0;
    waw     = '0;
    if (last_req.use_vs1 && wr_ok[last_req.vs1]) begin
      raw_vs1[wr_id[last_req.vs1]] = 1'b1;
    end
    if (last_req.use_vs2 && wr_ok[last_req.vs2]) begin
      raw_vs2[wr_id[last_req.vs2]] = 1'b1;
    end
    if (!last_req.vm && wr_ok[0]) begin
      raw_vm[wr_id[0]] = 1'b1;
    end
    if (last_req.use_vd && rd_ok[last_req.vd]) begin
      war[rd_id[last_req.vd]] = 1'b1;
    end
    if (last_req.use_vd && wr_ok[last_req.vd]) begin
      waw[wr_id[last_req.vd]] = 1'b1;
    end
  end

  // A finishing id must not have a producer still live
  always_comb begin : p_order
    order_bad = 1'b0;
    for (int i = 0; i < `VSEQ_NR_VINSN; i++) begin
      if (done_all[i] && (dep[i] & live) != '0) begin
        order_bad = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_model
    if (!rst_ni) begin
      last_req     <= '0;
      pe_live      <= '0;
      out_of_reset <= 1'b0;
      pending      <= 1'b0;
      exp_err      <= 1'b0;
      exp_scalar   <= 1'b0;
      exp_vl       <= '0;
      for (int v = 0; v < `VSEQ_NR_VREGS; v++) begin
        wr_id[v] <= '0;
        wr_ok[v] <= 1'b0;
        rd_id[v] <= '0;
        rd_ok[v] <= 1'b0;
      end
      for (int i = 0; i < `VSEQ_NR_VINSN; i++) begin
        dep[i] <= '0;
      end
    end else begin
      last_req     <= req_i;
      pe_live      <= pe_next;
      out_of_reset <= 1'b1;
      // Entries lapse when their id retires
      for (int v = 0; v < `VSEQ_NR_VREGS; v++) begin
        wr_ok[v] <= wr_ok[v] && live_next[wr_id[v]];
        rd_ok[v] <= rd_ok[v] && live_next[rd_id[v]];
      end
      for (int i = 0; i < `VSEQ_NR_VINSN; i++) begin
        dep[i] <= dep[i] & live_next;
      end
      if (resp_valid_o) begin
        pending <= 1'b0;
      end
      if (pe_req_valid_o) begin
        dep[pe_req_o.id] <= raw_vs1 | raw_vs2 | raw_vm | war | waw;
        if (last_req.use_vd) begin
          wr_id[last_req.vd] <= pe_req_o.id;
          wr_ok[last_req.vd] <= 1'b1;
        end
        if (last_req.use_vs1) begin
          rd_id[last_req.vs1] <= pe_req_o.id;
          rd_ok[last_req.vs1] <= 1'b1;
        end
        if (last_req.use_vs2) begin
          rd_id[last_req.vs2] <= pe_req_o.id;
          rd_ok[last_req.vs2] <= 1'b1;
        end
        if (!last_req.vm) begin
          rd_id[0] <= pe_req_o.id;
          rd_ok[0] <= 1'b1;
        end
        if (last_req.op == VLE || last_req.op == VSE || last_req.op == VCPOP) begin
          pending    <= 1'b1;
          exp_scalar <= last_req.op == VCPOP;
          exp_err    <= last_req.op != VCPOP && last_req.scalar_op[1:0] != 2'b00;
          exp_vl     <= last_req.vl;
        end
      end
    end
  end

  a_reset: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !out_of_reset |-> idle_o && !pe_req_valid_o && !resp_valid_o)
    else begin err_count++; $error("Outputs not quiet after reset"); end

  a_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      idle_o == (live == '0 && !pe_req_valid_o))
    else begin err_count++; $error("Fail idle_o %h live %h", idle_o, live); end

  a_free_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pe_req_valid_o |-> !live[pe_req_o.id])
    else begin err_count++; $error("Fail pe_req_o.id %h already live %h", pe_req_o.id, live); end

  a_issue_delay: assert property (@(posedge clk_i) disable iff (!rst_ni)
      req_valid_i && req_ready_o && !resp_valid_o |=> pe_req_valid_o)
    else begin err_count++; $error("Accepted request was not issued a cycle later"); end

  // Issued request carries what was dispatched
  a_req_fields: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pe_req_valid_o |-> pe_req_o.op == last_req.op && pe_req_o.vm == last_req.vm &&
        pe_req_o.vl == last_req.vl && pe_req_o.scalar_op == last_req.scalar_op)
    else begin
      err_count++;
      $error("Fail pe_req_o op %h vm %h vl %h scalar_op %h expected %h %h %h %h",
             pe_req_o.op, pe_req_o.vm, pe_req_o.vl, pe_req_o.scalar_op,
             last_req.op, last_req.vm, last_req.vl, last_req.scalar_op);
    end

  a_raw: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pe_req_valid_o |-> (raw_vs1 & ~pe_req_o.hazard_vs1) == '0 &&
        (raw_vs2 & ~pe_req_o.hazard_vs2) == '0 && (raw_vm & ~pe_req_o.hazard_vm) == '0)
    else begin
      err_count++;
      $error("Fail hazard_vs1 %h hazard_vs2 %h hazard_vm %h expected at least %h %h %h",
             pe_req_o.hazard_vs1, pe_req_o.hazard_vs2, pe_req_o.hazard_vm,
             raw_vs1, raw_vs2, raw_vm);
    end

  a_war_waw: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pe_req_valid_o |-> (waw & ~pe_req_o.hazard_vd) == '0 &&
        (war & ~(pe_req_o.hazard_vs1 | pe_req_o.hazard_vs2 | pe_req_o.hazard_vm)) == '0)
    else begin
      err_count++;
      $error("Fail hazard_vd %h expected at least %h, reader mask expected %h",
             pe_req_o.hazard_vd, waw, war);
    end

  a_order: assert property (@(posedge clk_i) disable iff (!rst_ni) !order_bad)
    else begin err_count++; $error("Dependent instruction finished before its producer"); end

  a_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
      resp_valid_o |-> pending && resp_o.error == exp_err &&
        (!exp_scalar || resp_o.result == xlen_t'(exp_vl)))
    else begin
      err_count++;
      $error("Fail resp_o error %h result %h expected %h %h pending %h",
             resp_o.error, resp_o.result, exp_err, exp_vl, pending);
    end

  a_one_commit: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pending |-> !pe_req_valid_o && (resp_valid_o || !req_ready_o))
    else begin err_count++; $error("Dispatch went on before the commit response"); end

  a_no_lost_commit: assert property (@(posedge clk_i) disable iff (!rst_ni)
      idle_o |-> !pending)
    else begin err_count++; $error("Unit went idle without a commit response"); end

  a_structural: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pe_req_valid_o |->
        !(last_req.op == VSE && pe_live[`VSEQ_PE_MASK] != '0) &&
        !((last_req.op == VMAND || last_req.op == VCPOP) && pe_live[`VSEQ_PE_STORE] != '0))
    else begin err_count++; $error("Store and mask instruction overlapped"); end

endmodule

// ==== bench/vseq_tb.sv ====
// Directed then seeded random dispatch; checking lives in the bound assertions
`timescale 1ns/10ps
`include "vseq_cfg.svh"

module vseq_tb import vseq_pkg::*; ();

  localparam int NR_RANDOM = 200;
  localparam int MAX_CYCLES = NR_RANDOM * 40 + 500;

  logic                           clk_i;
  logic                           rst_ni;
  disp_req_t                      req_i;
  logic                           req_valid_i;
  logic                           req_ready_o;
  disp_resp_t                     resp_o;
  logic                           resp_valid_o;
  logic                           idle_o;
  pe_req_t                        pe_req_o;
  logic                           pe_req_valid_o;
  vinsn_mask_t [`VSEQ_NR_PES-1:0] pe_done_o;
  int unsigned                    cycles;

  vseq_top dut_i (.*);

  bind vseq_top vseq_properties props_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .resp_o        (resp_o),
    .resp_valid_o  (resp_valid_o),
    .idle_o        (idle_o),
    .pe_req_o      (pe_req_o),
    .pe_req_valid_o(pe_req_valid_o),
    .pe_done_o     (pe_done_o)
  );

  initial begin : p_clock
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Stop at the first assertion failure or on timeout
  always @(posedge clk_i) begin : p_watchdog
    cycles <= cycles + 1;
    if (dut_i.props_i.err_count != 0) begin
      $display("TB FAILED");
      $fatal(1, "An assertion failed");
    end else if (cycles > MAX_CYCLES) begin
      $display("TB FAILED");
      $fatal(1, "Timeout after %0d cycles", cycles);
    end
  end

  // Register use follows the op class
  function automatic disp_req_t make_req(input vop_e op, input vreg_t vd, input vreg_t vs1,
                                         input vreg_t vs2, input logic vm, input vlen_t vl,
                                         input xlen_t sop);
    disp_req_t r;
    r           = '0;
    r.op        = op;
    r.vd        = vd;
    r.vs1       = vs1;
    r.vs2       = vs2;
    r.vm        = vm;
    r.vl        = vl;
    r.scalar_op = sop;
    r.use_vd    = op != VSE && op != VCPOP;
    r.use_vs1   = op == VADD || op == VMUL || op == VMAND;
    r.use_vs2   = op != VLE;
    return r;
  endfunction

  // Hold the request until the cycle it is taken
  task automatic send(input disp_req_t r);
    req_i       = r;
    req_valid_i = 1'b1;
    @(negedge clk_i);
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #10;
    req_valid_i = 1'b0;
  endtask

  initial begin : p_stimulus
    vop_e  op;
    vreg_t vd;
    vreg_t vs1;
    vreg_t vs2;
    cycles      = 0;
    rst_ni      = 1'b0;
    req_i       = '0;
    req_valid_i = 1'b0;
    void'($urandom(32'hfd91_0822));
    repeat (4) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #10;

    // Dependent pairs, RAW then WAR and WAW
    send(make_req(VADD, 5'd1, 5'd2, 5'd3, 1'b1, 8'd16, 32'h0));
    send(make_req(VMUL, 5'd4, 5'd1, 5'd1, 1'b1, 8'd3, 32'h0));
    send(make_req(VADD, 5'd2, 5'd5, 5'd6, 1'b1, 8'd5, 32'h0));
    send(make_req(VMUL, 5'd4, 5'd7, 5'd7, 1'b1, 8'd2, 32'h0));
    // Loads and stores, aligned and misaligned
    send(make_req(VLE, 5'd3, 5'd0, 5'd0, 1'b1, 8'd8, 32'h0000_0100));
    send(make_req(VLE, 5'd6, 5'd0, 5'd0, 1'b1, 8'd4, 32'h0000_0103));
    send(make_req(VSE, 5'd0, 5'd0, 5'd3, 1'b1, 8'd8, 32'h0000_0200));
    send(make_req(VSE, 5'd0, 5'd0, 5'd6, 1'b1, 8'd2, 32'h0000_0202));
    // Scalar answer and masked ops
    send(make_req(VCPOP, 5'd0, 5'd0, 5'd0, 1'b1, 8'd9, 32'h0));
    send(make_req(VADD, 5'd5, 5'd1, 5'd2, 1'b0, 8'd7, 32'h0));
    send(make_req(VMAND, 5'd0, 5'd1, 5'd2, 1'b1, 8'd12, 32'h0));
    // Store right behind a mask op
    send(make_req(VSE, 5'd0, 5'd0, 5'd5, 1'b1, 8'd4, 32'h0000_0300));
    send(make_req(VMAND, 5'd0, 5'd4, 5'd5, 1'b1, 8'd3, 32'h0));

    // Few registers so conflicts stay frequent
    for (int n = 0; n < NR_RANDOM; n++) begin
      op  = vop_e'($urandom % 6);
      vd  = vreg_t'($urandom % 8);
      vs1 = vreg_t'($urandom % 8);
      vs2 = vreg_t'($urandom % 8);
      send(make_req(op, vd, vs1, vs2, ($urandom % 4) != 0, vlen_t'(1 + $urandom % 16),
                    $urandom));
    end

    @(negedge clk_i);
    while (!idle_o) begin
      @(negedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    if (dut_i.props_i.err_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("TB FAILED");
      $fatal(1, "Assertion failures at the end of the run");
    end
  end

endmodule

// ==== vseq_top.f ====
+incdir+.
source/vseq_pkg.sv
source/vseq_decode.sv
source/vseq_sequencer.sv
source/vseq_units.sv
source/vseq_top.sv
bench/vseq_properties.sv
bench/vseq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the testbench, the exit status tells pass or fail
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timing --top-module vseq_tb -f vseq_top.f
# Assertion errors are counted by the testbench, which then ends the run itself
./obj_dir/Vvseq_tb +verilator+error+limit+1000
